// File: exec_pkg.sv
`default_nettype none

package exec_pkg;

	// operand width of the integer datapath
	localparam int xlen = 64;

	// reorder-buffer tag width, enough for 32 instructions in flight
	localparam int rob_tag_w = 5;

	// the multiplier is split into this many identical stages
	localparam int mult_stages = 8;

	// each stage consumes this many bits of the multiplier operand
	localparam int mult_slice = xlen / mult_stages;

	// ALU results the arbiter can hold while the multiplier owns the bus
	localparam int alu_queue_depth = 4;

	// queue pointers wrap on their own, so the depth has to be a power of two
	localparam int alu_queue_ptr_w = $clog2(alu_queue_depth);

	// the count must also represent a completely full queue
	localparam int alu_queue_cnt_w = $clog2(alu_queue_depth + 1);

	typedef logic [rob_tag_w-1:0] rob_tag_t;

	// shifts take their amount from the low 6 bits of operand b
	typedef enum logic [2:0] {
		alu_add  = 3'd0,
		alu_sub  = 3'd1,
		alu_and  = 3'd2,
		alu_or   = 3'd3,
		alu_xor  = 3'd4,
		alu_sll  = 3'd5,
		alu_srl  = 3'd6,
		alu_sltu = 3'd7
	} alu_op_t;

	// request to the multiplier, the product is mcand times mplier
	typedef struct packed {
		logic [xlen-1:0] mcand;
		logic [xlen-1:0] mplier;
		rob_tag_t        tag;
	} mult_req_t;

	typedef struct packed {
		alu_op_t         op;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		rob_tag_t        tag;
	} alu_req_t;

	// a finished value from either functional unit
	typedef struct packed {
		logic [xlen-1:0] value;
		rob_tag_t        tag;
	} fu_result_t;

	// state handed from one multiplier stage to the next
	typedef struct packed {
		logic [xlen-1:0] product;
		logic [xlen-1:0] mcand;
		logic [xlen-1:0] mplier;
		rob_tag_t        tag;
	} mult_stage_t;

	// one broadcast on the common data bus
	typedef struct packed {
		logic            valid;
		rob_tag_t        tag;
		logic [xlen-1:0] value;
	} cdb_t;

endpackage

`default_nettype wire

// File: mult_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mult_stage (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  exec_pkg::mult_stage_t stage_in,
	output logic                 done,
	output exec_pkg::mult_stage_t stage_out
);

	// the running product and the new partial product are kept apart until
	// after the register, so the adder sits on the output side of the stage
	logic [exec_pkg::xlen-1:0] product_reg;
	logic [exec_pkg::xlen-1:0] partial_reg;
	logic [exec_pkg::xlen-1:0] mcand_reg;
	logic [exec_pkg::xlen-1:0] mplier_reg;
	exec_pkg::rob_tag_t        tag_reg;

	logic [exec_pkg::xlen-1:0] partial_product;

	// only the low slice of the multiplier takes part in this stage, and
	// the product is truncated to the low xlen bits
	assign partial_product = stage_in.mplier[exec_pkg::mult_slice-1:0] * stage_in.mcand;

	always_ff @(posedge clock) begin
		product_reg <= stage_in.product;
		partial_reg <= partial_product;
		// the next stage sees the following slice in the low bits of mplier
		mplier_reg  <= stage_in.mplier >> exec_pkg::mult_slice;
		// and an mcand that is already weighted for that slice
		mcand_reg   <= stage_in.mcand << exec_pkg::mult_slice;
		tag_reg     <= stage_in.tag;
	end

	// the valid bit is the only control state in the stage
	always_ff @(posedge clock) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= start;
		end
	end

	always_comb begin
		stage_out.product = product_reg + partial_reg;
		stage_out.mcand   = mcand_reg;
		stage_out.mplier  = mplier_reg;
		stage_out.tag     = tag_reg;
	end

endmodule

`default_nettype wire

// File: multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module multiplier (
	input  logic                clock,
	input  logic                reset,
	input  logic                mult_start,
	input  exec_pkg::mult_req_t mult_req,
	output logic                mult_done,
	output exec_pkg::fu_result_t mult_result
);

	// entry i of each chain is the input of stage i, the last entry is the
	// output of the final stage
	logic                  start_chain [0:exec_pkg::mult_stages];
	exec_pkg::mult_stage_t stage_chain [0:exec_pkg::mult_stages];

	// a new product starts from zero
	always_comb begin
		start_chain[0]         = mult_start;
		stage_chain[0].product = '0;
		stage_chain[0].mcand   = mult_req.mcand;
		stage_chain[0].mplier  = mult_req.mplier;
		stage_chain[0].tag     = mult_req.tag;
	end

	// every stage registers its inputs, so a request needs exactly
	// mult_stages cycles to reach the end of the chain
	for (genvar i = 0; i < exec_pkg::mult_stages; i++) begin : stage_g
		mult_stage stage_i (
			.clock     (clock),
			.reset     (reset),
			.start     (start_chain[i]),
			.stage_in  (stage_chain[i]),
			.done      (start_chain[i+1]),
			.stage_out (stage_chain[i+1])
		);
	end

	// by now mplier has been shifted out completely and only the product matters
	assign mult_done         = start_chain[exec_pkg::mult_stages];
	assign mult_result.value = stage_chain[exec_pkg::mult_stages].product;
	assign mult_result.tag   = stage_chain[exec_pkg::mult_stages].tag;

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic                clock,
	input  logic                reset,
	input  logic                alu_start,
	input  exec_pkg::alu_req_t  alu_req,
	output logic                alu_done,
	output exec_pkg::fu_result_t alu_result
);

	logic [exec_pkg::xlen-1:0] value;
	logic [5:0]                shamt;

	// shift amounts come from the low 6 bits of b, covering 0 to 63
	assign shamt = alu_req.b[5:0];

	always_comb begin
		value = '0;
		case (alu_req.op)
			exec_pkg::alu_add: begin
				value = alu_req.a + alu_req.b;
			end
			exec_pkg::alu_sub: begin
				value = alu_req.a - alu_req.b;
			end
			exec_pkg::alu_and: begin
				value = alu_req.a & alu_req.b;
			end
			exec_pkg::alu_or: begin
				value = alu_req.a | alu_req.b;
			end
			exec_pkg::alu_xor: begin
				value = alu_req.a ^ alu_req.b;
			end
			exec_pkg::alu_sll: begin
				value = alu_req.a << shamt;
			end
			exec_pkg::alu_srl: begin
				// logical shift, zeros come in from the top
				value = alu_req.a >> shamt;
			end
			exec_pkg::alu_sltu: begin
				// unsigned compare, the flag lands in bit 0
				value = {{(exec_pkg::xlen-1){1'b0}}, alu_req.a < alu_req.b};
			end
			default: begin
				value = '0;
			end
		endcase
	end

	// the result only changes when a request is accepted
	always_ff @(posedge clock) begin
		if (alu_start) begin
			alu_result.value <= value;
			alu_result.tag   <= alu_req.tag;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			alu_done <= 1'b0;
		end else begin
			alu_done <= alu_start;
		end
	end

endmodule

`default_nettype wire

// File: cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 mult_done,
	input  exec_pkg::fu_result_t mult_result,
	input  logic                 alu_done,
	input  exec_pkg::fu_result_t alu_result,
	output exec_pkg::cdb_t       cdb,
	output logic                 alu_full
);

	// circular queue of ALU results that lost the bus
	exec_pkg::fu_result_t queue_mem [0:exec_pkg::alu_queue_depth-1];

	logic [exec_pkg::alu_queue_ptr_w-1:0] rd_ptr;
	logic [exec_pkg::alu_queue_ptr_w-1:0] wr_ptr;
	logic [exec_pkg::alu_queue_cnt_w-1:0] count;

	logic queue_empty;
	logic queue_at_depth;
	logic drain;
	logic push;

	logic                 cdb_valid;
	exec_pkg::fu_result_t cdb_data;

	assign queue_empty    = (count == '0);
	assign queue_at_depth = (count == exec_pkg::alu_queue_cnt_w'(exec_pkg::alu_queue_depth));

	// the head goes out in every cycle the multiplier leaves the bus free
	assign drain = !mult_done && !queue_empty;

	// a fresh ALU result bypasses the queue only when nothing is waiting and
	// the multiplier is idle, otherwise it has to wait behind older results
	// (a result that arrives on a full queue is dropped)
	assign push = alu_done && (mult_done || !queue_empty) && !queue_at_depth;

	// full also covers the last free slot being taken right now
	assign alu_full = queue_at_depth ||
		(count == exec_pkg::alu_queue_cnt_w'(exec_pkg::alu_queue_depth - 1) && push && !drain);

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (drain) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// a push and a drain in the same cycle leave the count alone
			if (push && !drain) begin
				count <= count + 1'b1;
			end else if (drain && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			queue_mem[wr_ptr] <= alu_result;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= mult_done || alu_done || !queue_empty;
		end
	end

	// priority is multiplier, then the oldest queued result, then a fresh one
	always_ff @(posedge clock) begin
		if (mult_done) begin
			cdb_data <= mult_result;
		end else if (!queue_empty) begin
			cdb_data <= queue_mem[rd_ptr];
		end else begin
			cdb_data <= alu_result;
		end
	end

	assign cdb = '{valid: cdb_valid, tag: cdb_data.tag, value: cdb_data.value};

endmodule

`default_nettype wire

// File: exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  logic                clock,
	input  logic                reset,
	input  logic                mult_start,
	input  exec_pkg::mult_req_t mult_req,
	input  logic                alu_start,
	input  exec_pkg::alu_req_t  alu_req,
	output exec_pkg::cdb_t      cdb,
	output logic                alu_full
);

	logic                 mult_done;
	exec_pkg::fu_result_t mult_result;
	logic                 alu_done;
	exec_pkg::fu_result_t alu_result;

	// eight cycles from start to done, several products in flight
	multiplier multiplier_i (
		.clock       (clock),
		.reset       (reset),
		.mult_start  (mult_start),
		.mult_req    (mult_req),
		.mult_done   (mult_done),
		.mult_result (mult_result)
	);

	// one cycle from start to done
	alu alu_i (
		.clock      (clock),
		.reset      (reset),
		.alu_start  (alu_start),
		.alu_req    (alu_req),
		.alu_done   (alu_done),
		.alu_result (alu_result)
	);

	// both units meet here and share the single broadcast bus
	cdb_arbiter cdb_arbiter_i (
		.clock       (clock),
		.reset       (reset),
		.mult_done   (mult_done),
		.mult_result (mult_result),
		.alu_done    (alu_done),
		.alu_result  (alu_result),
		.cdb         (cdb),
		.alu_full    (alu_full)
	);

endmodule

`default_nettype wire

// File: tb_exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit;

	logic                 clock;
	logic                 reset;
	logic                 mult_start;
	exec_pkg::mult_req_t  mult_req;
	logic                 alu_start;
	exec_pkg::alu_req_t   alu_req;
	exec_pkg::cdb_t       cdb;
	logic                 alu_full;

	// a multiplier expectation carries the cycle in which it must show up
	typedef struct packed {
		int                 due;
		exec_pkg::rob_tag_t tag;
		logic [63:0]        value;
	} mult_exp_t;

	mult_exp_t            mq[$];
	exec_pkg::fu_result_t aq[$];

	logic [31:0]        lfsr_state = 32'h7da6_8478;
	logic [31:0]        tag_busy = '0;
	exec_pkg::rob_tag_t tag_hint = '0;
	exec_pkg::rob_tag_t last_alu_tag = '0;

	// model state of the arbiter is updated on the falling edge
	int          cyc = 0;
	int          model_count = 0;
	logic [7:0]  mult_hist = '0;
	logic        alu_prev = 1'b0;
	logic        alu_out_expected = 1'b0;
	logic        full_pred = 1'b0;
	logic        saw_full = 1'b0;

	int checks = 0;
	int value_errors = 0;
	int flow_errors = 0;
	int reset_errors = 0;
	int protocol_errors = 0;

	exec_unit exec_unit_i (
		.clock      (clock),
		.reset      (reset),
		.mult_start (mult_start),
		.mult_req   (mult_req),
		.alu_start  (alu_start),
		.alu_req    (alu_req),
		.cdb        (cdb),
		.alu_full   (alu_full)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// right-shifting Galois LFSR with taps at 32, 30, 26 and 25
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[62:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// all-ones and zero come up often enough to hit the corners
	function automatic logic [63:0] rand_operand();
		logic [63:0] sel;
		sel = rand_bits(3);
		if (sel == 64'd0) return '1;
		if (sel == 64'd1) return '0;
		return rand_bits(64);
	endfunction

	function automatic logic [63:0] alu_expect(input exec_pkg::alu_op_t op,
		input logic [63:0] a, input logic [63:0] b);
		case (op)
			exec_pkg::alu_add: return a + b;
			exec_pkg::alu_sub: return a - b;
			exec_pkg::alu_and: return a & b;
			exec_pkg::alu_or: return a | b;
			exec_pkg::alu_xor: return a ^ b;
			exec_pkg::alu_sll: return a << b[5:0];
			exec_pkg::alu_srl: return a >> b[5:0];
			default: return (a < b) ? 64'd1 : 64'd0;
		endcase
	endfunction

	// the queue head leaves whenever the multiplier does not own the bus
	function automatic logic queue_drain(input int count, input logic md);
		return !md && count > 0;
	endfunction

	// an ALU result waits when something is queued or the multiplier collides
	function automatic logic queue_push(input int count, input logic ad, input logic md);
		return ad && (md || count > 0);
	endfunction

	function automatic logic full_rule(input int count, input logic push, input logic drain);
		return count == exec_pkg::alu_queue_depth ||
			(count == exec_pkg::alu_queue_depth - 1 && push && !drain);
	endfunction

	// first free tag at or after the rotating hint
	function automatic exec_pkg::rob_tag_t pick_tag(input logic [31:0] taken);
		exec_pkg::rob_tag_t t;
		t = tag_hint;
		for (int i = 0; i < 32; i++) begin
			if (taken[t]) t = t + 5'd1;
		end
		return t;
	endfunction

	task automatic expect_equal(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got == exp) else begin
			value_errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	// the issuer must never have an ALU request out while alu_full is high
	issue_rule_a: assert property (@(posedge clock) disable iff (reset) alu_start |-> !alu_full)
		else begin
			protocol_errors++;
			$display("an ALU request was issued while alu_full was high");
		end

	reset_quiet_a: assert property (@(posedge clock) reset |=> (!cdb.valid && !alu_full))
		else begin
			reset_errors++;
			$display("Error: cdb.valid is %h and alu_full is %h after reset, expected 0 and 0",
				$sampled(cdb.valid), $sampled(alu_full));
		end

	// outputs are stable at the falling edge, and the inputs seen here are
	// the ones the DUT captures on the next rising edge
	always @(negedge clock) begin : scoreboard
		mult_exp_t            mexp;
		exec_pkg::fu_result_t aexp;
		logic                 md;
		logic                 ad;
		logic                 push;
		logic                 drain;
		if (reset) begin
			cyc = 0;
			model_count = 0;
			mult_hist = '0;
			alu_prev = 1'b0;
			alu_out_expected = 1'b0;
			full_pred = 1'b0;
			expect_equal("cdb.valid", 64'(cdb.valid), 64'd0);
			expect_equal("alu_full", 64'(alu_full), 64'd0);
		end else begin
			cyc = cyc + 1;
			if (mq.size() > 0 && mq[0].due == cyc) begin
				mexp = mq.pop_front();
				expect_equal("cdb.valid", 64'(cdb.valid), 64'd1);
				expect_equal("cdb.tag", 64'(cdb.tag), 64'(mexp.tag));
				expect_equal("cdb.value", cdb.value, mexp.value);
				tag_busy[mexp.tag] = 1'b0;
			end else if (alu_out_expected) begin
				if (aq.size() == 0) begin
					flow_errors++;
					$display("an ALU broadcast was due with no ALU request outstanding");
				end else begin
					aexp = aq.pop_front();
					expect_equal("cdb.valid", 64'(cdb.valid), 64'd1);
					expect_equal("cdb.tag", 64'(cdb.tag), 64'(aexp.tag));
					expect_equal("cdb.value", cdb.value, aexp.value);
					tag_busy[aexp.tag] = 1'b0;
				end
			end else begin
				expect_equal("cdb.valid", 64'(cdb.valid), 64'd0);
			end
			// done strobes of this cycle come from the recorded start history
			md = mult_hist[7];
			ad = alu_prev;
			push = queue_push(model_count, ad, md);
			drain = queue_drain(model_count, md);
			expect_equal("alu_full", 64'(alu_full), 64'(full_rule(model_count, push, drain)));
			if (alu_full) saw_full = 1'b1;
			alu_out_expected = !md && (ad || model_count > 0);
			if (push && !drain) begin
				model_count = model_count + 1;
			end else if (drain && !push) begin
				model_count = model_count - 1;
			end
			if (mult_start) begin
				mexp.due = cyc + 9;
				mexp.tag = mult_req.tag;
				mexp.value = mult_req.mcand * mult_req.mplier;
				mq.push_back(mexp);
				tag_busy[mult_req.tag] = 1'b1;
			end
			if (alu_start) begin
				aexp.value = alu_expect(alu_req.op, alu_req.a, alu_req.b);
				aexp.tag = alu_req.tag;
				aq.push_back(aexp);
				tag_busy[alu_req.tag] = 1'b1;
			end
			mult_hist = {mult_hist[6:0], mult_start};
			alu_prev = alu_start;
			// lets the driver hold back an ALU request the next cycle
			push = queue_push(model_count, alu_prev, mult_hist[7]);
			drain = queue_drain(model_count, mult_hist[7]);
			full_pred = full_rule(model_count, push, drain);
		end
	end

	task automatic issue(input logic want_mult, input logic [63:0] mcand,
		input logic [63:0] mplier, input logic want_alu, input exec_pkg::alu_op_t op,
		input logic [63:0] a, input logic [63:0] b);
		logic [31:0]        taken;
		exec_pkg::rob_tag_t mtag;
		exec_pkg::rob_tag_t atag;
		logic               send_alu;
		@(posedge clock);
		taken = tag_busy;
		mtag = pick_tag(taken);
		taken[mtag] = 1'b1;
		atag = pick_tag(taken);
		tag_hint = atag + 5'd1;
		send_alu = want_alu && !full_pred;
		mult_start <= want_mult;
		mult_req <= '{mcand: mcand, mplier: mplier, tag: mtag};
		alu_start <= send_alu;
		alu_req <= '{op: op, a: a, b: b, tag: atag};
		if (send_alu) last_alu_tag = atag;
	endtask

	task automatic idle_cycle();
		issue(1'b0, '0, '0, 1'b0, exec_pkg::alu_add, '0, '0);
	endtask

	task automatic random_cycle(input logic want_mult, input logic want_alu);
		logic [63:0] mc;
		logic [63:0] mp;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] bits;
		mc = rand_operand();
		mp = rand_operand();
		a = rand_operand();
		b = rand_operand();
		bits = rand_bits(3);
		issue(want_mult, mc, mp, want_alu, exec_pkg::alu_op_t'(bits[2:0]), a, b);
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic wait_idle(input string what, input int limit);
		int n;
		n = 0;
		idle_cycle();
		while ((mq.size() != 0 || aq.size() != 0) && n < limit) begin
			idle_cycle();
			n++;
		end
		if (mq.size() != 0 || aq.size() != 0) report_timeout(what);
	endtask

	initial begin
		int          n;
		int          stream_n;
		logic        found;
		logic [63:0] a;
		logic [63:0] b;
		reset = 1'b1;
		mult_start = 1'b0;
		mult_req = '0;
		alu_start = 1'b0;
		alu_req = '0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;

		// back-to-back products with the corner operands first
		issue(1'b1, '1, '1, 1'b0, exec_pkg::alu_add, '0, '0);
		issue(1'b1, '0, rand_bits(64), 1'b0, exec_pkg::alu_add, '0, '0);
		issue(1'b1, rand_bits(64), '1, 1'b0, exec_pkg::alu_add, '0, '0);
		for (int k = 0; k < 13; k++) random_cycle(1'b1, 1'b0);
		wait_idle("the multiplier burst", 40);

		// each opcode is sent twice alone on the bus and takes two cycles to the cdb
		for (int k = 0; k < 16; k++) begin
			a = rand_operand();
			b = rand_operand();
			issue(1'b0, '0, '0, 1'b1, exec_pkg::alu_op_t'(k[2:0]), a, b);
			n = 0;
			found = 1'b0;
			while (!found && n < 10) begin
				idle_cycle();
				@(negedge clock);
				n++;
				if (cdb.valid && cdb.tag == last_alu_tag) found = 1'b1;
			end
			if (!found) begin
				report_timeout("an isolated ALU result");
			end else begin
				assert (n == 2) else begin
					flow_errors++;
					$display("Error: ALU latency is %0h cycles, expected %0h", n, 2);
				end
			end
		end

		// random mix so that completions collide and the queue is used
		for (int k = 0; k < 80; k++) begin
			a = rand_bits(2);
			random_cycle(a[0], a[1]);
		end
		wait_idle("the mixed traffic", 60);

		// a steady multiplier stream starves the ALU until the queue fills
		saw_full = 1'b0;
		stream_n = 0;
		while (!saw_full && stream_n < 40) begin
			random_cycle(1'b1, 1'b1);
			stream_n++;
		end
		if (!saw_full) begin
			flow_errors++;
			$display("alu_full never rose during the multiplier stream");
		end
		repeat (6) random_cycle(1'b1, 1'b0);
		wait_idle("the ALU queue to drain", 60);
		@(negedge clock);
		assert (!alu_full) else begin
			flow_errors++;
			$display("Error: alu_full is %h after the drain, expected %h", alu_full, 1'b0);
		end

		$display("checks %0d, errors: value %0d, flow %0d, reset %0d, protocol %0d",
			checks, value_errors, flow_errors, reset_errors, protocol_errors);
		if (value_errors + flow_errors + reset_errors + protocol_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
exec_pkg.sv
mult_stage.sv
multiplier.sv
alu.sv
cdb_arbiter.sv
exec_unit.sv
tb_exec_unit.sv

// File: Makefile
# Verilator build and run of the execute cluster testbench

TOP := tb_exec_unit
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

# the run passes only if the log holds the pass line
test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
